//--- hw/core_pkg.sv
package core_pkg;

localparam int XLEN = 32;

typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_EQ,   // Compares return 0/1 in bit 0
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
} alu_operation_t;

// RV32I major opcodes
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;

//////////////////////////////////////////////////
// Instruction formats, MSB first

typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
} r_type_t;

typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} i_type_t;

typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
} s_type_t;

typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
} b_type_t;

typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} u_type_t;

typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
} j_type_t;

// Same word, read through whichever format decode needs
typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    s_type_t s_type;
    b_type_t b_type;
    u_type_t u_type;
    j_type_t j_type;
} rv_instr_u;

endpackage

//--- hw/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  alu_operation_t  operation_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    output logic [XLEN-1:0] res_o
);

logic [4:0] shamt;
logic       eq;
logic       lt_s;
logic       lt_u;

assign shamt = op2_i[4:0];  // Only low five bits shift
assign eq    = (op1_i == op2_i);
assign lt_s  = ($signed(op1_i) < $signed(op2_i));
assign lt_u  = (op1_i < op2_i);

always_comb begin
    case (operation_i)
        ALU_ADD:  res_o = op1_i + op2_i;
        ALU_SUB:  res_o = op1_i - op2_i;
        ALU_SLL:  res_o = op1_i << shamt;
        ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
        ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
        ALU_XOR:  res_o = op1_i ^ op2_i;
        ALU_SRL:  res_o = op1_i >> shamt;
        ALU_SRA:  res_o = $unsigned($signed(op1_i) >>> shamt);
        ALU_OR:   res_o = op1_i | op2_i;
        ALU_AND:  res_o = op1_i & op2_i;
        // Branch compares
        ALU_EQ:   res_o = {{(XLEN-1){1'b0}}, eq};
        ALU_NE:   res_o = {{(XLEN-1){1'b0}}, !eq};
        ALU_LT:   res_o = {{(XLEN-1){1'b0}}, lt_s};
        ALU_GE:   res_o = {{(XLEN-1){1'b0}}, !lt_s};
        ALU_LTU:  res_o = {{(XLEN-1){1'b0}}, lt_u};
        ALU_GEU:  res_o = {{(XLEN-1){1'b0}}, !lt_u};
    endcase
end

endmodule

//--- hw/id_decode.sv
`timescale 1ns/1ps

module id_decode import core_pkg::*; (
    input  rv_instr_u       instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            valid_i,

    // Bypass from EX
    input  logic [4:0]      ex_rd_addr_i,
    input  logic            ex_reg_wen_i,
    input  logic [XLEN-1:0] ex_result_i,

    // Register file read
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,

    // To EX
    output alu_operation_t  alu_operation_o,
    output logic [XLEN-1:0] alu_operand_1_o,
    output logic [XLEN-1:0] alu_operand_2_o,
    output logic [4:0]      rd_addr_o,
    output logic            reg_wen_o,
    output logic            is_branch_o,
    output logic            is_jump_o,
    output logic [XLEN-1:0] branch_target_o,
    output logic            valid_o
);

logic [XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
logic [XLEN-1:0] rs1_val, rs2_val;
logic [XLEN-1:0] jalr_sum;
logic [2:0]      funct3;
logic            f7_ok;      // funct7 is 0000000 or 0100000
logic            supported;
logic            rd_wen;

// Shared by OP and OP-IMM
function automatic alu_operation_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
        3'b000:  return alt ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return alt ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

assign funct3     = instr_i.r_type.funct3;
assign f7_ok      = (instr_i.r_type.funct7 & 7'b1011111) == 7'b0;
assign rs1_addr_o = instr_i.r_type.rs1;
assign rs2_addr_o = instr_i.r_type.rs2;
assign rd_addr_o  = instr_i.r_type.rd;

//////////////////////////////////////////////////
// Immediates

assign imm_i = {{(XLEN-12){instr_i.i_type.imm[11]}}, instr_i.i_type.imm};
assign imm_u = {instr_i.u_type.imm_31_12, 12'b0};
assign imm_b = {{(XLEN-12){instr_i.b_type.imm_12}}, instr_i.b_type.imm_11,
                instr_i.b_type.imm_10_5, instr_i.b_type.imm_4_1, 1'b0};
assign imm_j = {{(XLEN-20){instr_i.j_type.imm_20}}, instr_i.j_type.imm_19_12,
                instr_i.j_type.imm_11, instr_i.j_type.imm_10_1, 1'b0};

// EX result wins over the register file, x0 excluded
assign rs1_val = (ex_reg_wen_i && ex_rd_addr_i == rs1_addr_o && rs1_addr_o != 5'd0) ?
                 ex_result_i : rs1_data_i;
assign rs2_val = (ex_reg_wen_i && ex_rd_addr_i == rs2_addr_o && rs2_addr_o != 5'd0) ?
                 ex_result_i : rs2_data_i;

assign jalr_sum = rs1_val + imm_i;

always_comb begin
    alu_operation_o = ALU_ADD;
    alu_operand_1_o = rs1_val;
    alu_operand_2_o = rs2_val;
    branch_target_o = pc_i + imm_b;
    is_branch_o     = 1'b0;
    is_jump_o       = 1'b0;
    rd_wen          = 1'b1;
    supported       = 1'b1;
    case (instr_i.r_type.opcode)
        OPC_OP: begin
            alu_operation_o = arith_op(funct3, instr_i.r_type.funct7[5]);
            supported       = f7_ok;  // Rejects M extension
        end
        OPC_OP_IMM: begin
            alu_operation_o = arith_op(funct3, funct3 == 3'b101 && instr_i.r_type.funct7[5]);
            alu_operand_2_o = imm_i;
            if (funct3 == 3'b001 || funct3 == 3'b101) begin
                supported = f7_ok;
            end
        end
        OPC_LUI: begin
            alu_operand_1_o = '0;
            alu_operand_2_o = imm_u;
        end
        OPC_AUIPC: begin
            alu_operand_1_o = pc_i;
            alu_operand_2_o = imm_u;
        end
        OPC_JAL, OPC_JALR: begin
            alu_operand_1_o = pc_i;          // Link value pc+4
            alu_operand_2_o = XLEN'(4);
            is_jump_o       = 1'b1;
            if (instr_i.r_type.opcode == OPC_JAL) begin
                branch_target_o = pc_i + imm_j;
            end else begin
                branch_target_o = {jalr_sum[XLEN-1:1], 1'b0};
                supported       = (funct3 == 3'b000);
            end
        end
        OPC_BRANCH: begin
            is_branch_o = 1'b1;
            rd_wen      = 1'b0;
            case (funct3)
                3'b000:  alu_operation_o = ALU_EQ;
                3'b001:  alu_operation_o = ALU_NE;
                3'b100:  alu_operation_o = ALU_LT;
                3'b101:  alu_operation_o = ALU_GE;
                3'b110:  alu_operation_o = ALU_LTU;
                3'b111:  alu_operation_o = ALU_GEU;
                default: supported = 1'b0;
            endcase
        end
        default: begin
            supported = 1'b0;  // Becomes a bubble
            rd_wen    = 1'b0;
        end
    endcase
end

assign valid_o   = valid_i && supported;
assign reg_wen_o = valid_o && rd_wen;

endmodule

//--- hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import core_pkg::*; #(
    parameter bit ISA_C = 1'b0
) (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // From ID
    input  alu_operation_t  alu_operation_id_i,
    input  logic [XLEN-1:0] alu_operand_1_id_i,
    input  logic [XLEN-1:0] alu_operand_2_id_i,
    input  logic [4:0]      rd_addr_id_i,
    input  logic            reg_wen_id_i,
    input  logic            is_branch_id_i,
    input  logic            is_jump_id_i,
    input  logic [XLEN-1:0] branch_target_id_i,
    input  logic [XLEN-1:0] pc_id_i,
    input  logic            valid_id_i,

    // Control
    input  logic            stall_ex_i,
    input  logic            flush_ex_i,

    // To result stage and bypass
    output logic [4:0]      rd_addr_ex_o,
    output logic            reg_wen_ex_o,
    output logic            valid_ex_o,
    output logic [XLEN-1:0] alu_result_ex_o,

    // Next fetch and trap
    output logic [XLEN-1:0] branch_target_ex_o,
    output logic            branch_decision_ex_o,
    output logic            trap_ex_o
);

alu_operation_t  alu_operation_ex;
logic [XLEN-1:0] alu_operand_1_ex, alu_operand_2_ex;
logic [XLEN-1:0] target_ex;
logic [XLEN-1:0] pc_ex;
logic            is_branch_ex;
logic            is_jump_ex;

//////////////////////////////////////////////////
// ID -> EX register

always_ff @(posedge clk_i, negedge rst_n_i) begin
    if (!rst_n_i) begin
        valid_ex_o   <= 1'b0;
        reg_wen_ex_o <= 1'b0;
        is_branch_ex <= 1'b0;
        is_jump_ex   <= 1'b0;
    end else if (!stall_ex_i) begin
        if (flush_ex_i) begin
            // Bubble in place of the cancelled instruction
            valid_ex_o   <= 1'b0;
            reg_wen_ex_o <= 1'b0;
            is_branch_ex <= 1'b0;
            is_jump_ex   <= 1'b0;
        end else begin
            valid_ex_o   <= valid_id_i;
            reg_wen_ex_o <= reg_wen_id_i;
            is_branch_ex <= is_branch_id_i;
            is_jump_ex   <= is_jump_id_i;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (!stall_ex_i) begin
        alu_operation_ex <= alu_operation_id_i;
        alu_operand_1_ex <= alu_operand_1_id_i;
        alu_operand_2_ex <= alu_operand_2_id_i;
        rd_addr_ex_o     <= rd_addr_id_i;
        target_ex        <= branch_target_id_i;
        pc_ex            <= pc_id_i;
    end
end

alu alu0 (
    .operation_i ( alu_operation_ex ),
    .op1_i       ( alu_operand_1_ex ),
    .op2_i       ( alu_operand_2_ex ),
    .res_o       ( alu_result_ex_o  )
);

// Jumps always taken, branches on compare bit
assign branch_decision_ex_o = valid_ex_o && (is_jump_ex || (is_branch_ex && alu_result_ex_o[0]));

// Fall-through address when not taken
assign branch_target_ex_o = branch_decision_ex_o ? target_ex : pc_ex + XLEN'(4);

// Misaligned target only matters without compressed instructions
assign trap_ex_o = (ISA_C == 1'b0) && branch_decision_ex_o && target_ex[1];

endmodule

//--- hw/wb_result.sv
`timescale 1ns/1ps

module wb_result import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // From EX
    input  logic [4:0]      rd_addr_ex_i,
    input  logic            reg_wen_ex_i,
    input  logic            valid_ex_i,
    input  logic [XLEN-1:0] alu_result_ex_i,
    input  logic            stall_i,

    // Read ports for decode
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,

    // Retired write
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o
);

logic [XLEN-1:0] rf_q [32];
logic            rf_wen;

// No write while EX holds, x0 never written
assign rf_wen = valid_ex_i && reg_wen_ex_i && !stall_i && (rd_addr_ex_i != 5'd0);

always_ff @(posedge clk_i) begin
    if (rf_wen) begin
        rf_q[rd_addr_ex_i] <= alu_result_ex_i;
    end
end

//////////////////////////////////////////////////
// Write-through read ports

assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 :
                    (rf_wen && rd_addr_ex_i == rs1_addr_i) ? alu_result_ex_i :
                    rf_q[rs1_addr_i];
assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 :
                    (rf_wen && rd_addr_ex_i == rs2_addr_i) ? alu_result_ex_i :
                    rf_q[rs2_addr_i];

// Retire report follows the register file write
always_ff @(posedge clk_i, negedge rst_n_i) begin
    if (!rst_n_i) begin
        wb_valid_o <= 1'b0;
    end else begin
        wb_valid_o <= rf_wen;
    end
end

always_ff @(posedge clk_i) begin
    if (rf_wen) begin
        wb_rd_o   <= rd_addr_ex_i;
        wb_data_o <= alu_result_ex_i;
    end
end

endmodule

//--- hw/exec_core_top.sv
`timescale 1ns/1ps

module exec_core_top import core_pkg::*; #(
    parameter bit ISA_C = 1'b0
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            instr_valid_i,
    input  logic            stall_i,
    output logic            branch_taken_o,
    output logic [XLEN-1:0] branch_target_o,
    output logic            trap_o,
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o
);

// Register file read
logic [4:0]      rs1_addr, rs2_addr;
logic [XLEN-1:0] rs1_data, rs2_data;

// Decode -> execute
alu_operation_t  alu_operation_id;
logic [XLEN-1:0] alu_operand_1_id, alu_operand_2_id;
logic [4:0]      rd_addr_id;
logic            reg_wen_id;
logic            is_branch_id;
logic            is_jump_id;
logic [XLEN-1:0] branch_target_id;
logic            valid_id;

// Execute -> result and bypass
logic [4:0]      rd_addr_ex;
logic            reg_wen_ex;
logic            valid_ex;
logic [XLEN-1:0] alu_result_ex;
logic            branch_decision;

id_decode dec0 (
    .instr_i         ( instr_i          ),
    .pc_i            ( pc_i             ),
    .valid_i         ( instr_valid_i    ),
    .ex_rd_addr_i    ( rd_addr_ex       ),
    .ex_reg_wen_i    ( reg_wen_ex       ),
    .ex_result_i     ( alu_result_ex    ),
    .rs1_data_i      ( rs1_data         ),
    .rs2_data_i      ( rs2_data         ),
    .rs1_addr_o      ( rs1_addr         ),
    .rs2_addr_o      ( rs2_addr         ),
    .alu_operation_o ( alu_operation_id ),
    .alu_operand_1_o ( alu_operand_1_id ),
    .alu_operand_2_o ( alu_operand_2_id ),
    .rd_addr_o       ( rd_addr_id       ),
    .reg_wen_o       ( reg_wen_id       ),
    .is_branch_o     ( is_branch_id     ),
    .is_jump_o       ( is_jump_id       ),
    .branch_target_o ( branch_target_id ),
    .valid_o         ( valid_id         )
);

ex_stage #(
    .ISA_C ( ISA_C )
) ex0 (
    .clk_i                ( clk_i            ),
    .rst_n_i              ( rst_n_i          ),
    .alu_operation_id_i   ( alu_operation_id ),
    .alu_operand_1_id_i   ( alu_operand_1_id ),
    .alu_operand_2_id_i   ( alu_operand_2_id ),
    .rd_addr_id_i         ( rd_addr_id       ),
    .reg_wen_id_i         ( reg_wen_id       ),
    .is_branch_id_i       ( is_branch_id     ),
    .is_jump_id_i         ( is_jump_id       ),
    .branch_target_id_i   ( branch_target_id ),
    .pc_id_i              ( pc_i             ),
    .valid_id_i           ( valid_id         ),
    .stall_ex_i           ( stall_i          ),
    .flush_ex_i           ( branch_decision  ),  // Cancels the next offer
    .rd_addr_ex_o         ( rd_addr_ex       ),
    .reg_wen_ex_o         ( reg_wen_ex       ),
    .valid_ex_o           ( valid_ex         ),
    .alu_result_ex_o      ( alu_result_ex    ),
    .branch_target_ex_o   ( branch_target_o  ),
    .branch_decision_ex_o ( branch_decision  ),
    .trap_ex_o            ( trap_o           )
);

wb_result wb0 (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .rd_addr_ex_i    ( rd_addr_ex    ),
    .reg_wen_ex_i    ( reg_wen_ex    ),
    .valid_ex_i      ( valid_ex      ),
    .alu_result_ex_i ( alu_result_ex ),
    .stall_i         ( stall_i       ),
    .rs1_addr_i      ( rs1_addr      ),
    .rs2_addr_i      ( rs2_addr      ),
    .rs1_data_o      ( rs1_data      ),
    .rs2_data_o      ( rs2_data      ),
    .wb_valid_o      ( wb_valid_o    ),
    .wb_rd_o         ( wb_rd_o       ),
    .wb_data_o       ( wb_data_o     )
);

assign branch_taken_o = branch_decision;

endmodule

//--- bench/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core import core_pkg::*; ();

localparam int N_RANDOM  = 200;
localparam int N_CHAIN   = 30;
localparam int N_BRANCH  = 60;
localparam int N_JUMP    = 24;
localparam int N_STALLED = 100;
localparam int DRAIN     = 4;
// Reset, six tests with their drains, then a margin
localparam int MAX_CYCLES = 10 + (20 + DRAIN) + (30 + N_RANDOM + DRAIN)
                          + (60 + 3 * N_CHAIN + DRAIN) + (2 * N_BRANCH + DRAIN)
                          + (3 * N_JUMP + DRAIN) + (2 * N_STALLED + DRAIN) + 100;

logic        clk = 1'b0;
logic        rst_n;
logic [31:0] instr, pc;
logic        instr_valid, stall;
logic        branch_taken, trap, wb_valid;
logic [31:0] branch_target, wb_data;
logic [4:0]  wb_rd;

logic [31:0] seed = 32'hffe9_d089;
logic [31:0] shadow [32];              // Architectural register model
logic [31:0] base_vals [16];
logic [31:0] chain [N_CHAIN];
logic [4:0]  exp_rd_q [$];
logic [31:0] exp_data_q [$];
logic [31:0] cur_pc;
logic        ex_valid, ex_wr, ex_taken, ex_trap;  // What EX should show this cycle
logic [31:0] ex_target;
logic        exp_wb_valid;
logic        p_wr, p_taken, p_trap;     // Prediction for the word on offer
logic [4:0]  p_rd;
logic [31:0] p_data, p_target;
logic        accepted;
int          errors, checks, cycles, tests_run, tests_failed, errors_at_start;

exec_core_top #(
    .ISA_C ( 1'b0 )
) dut0 (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .instr_i         ( instr         ),
    .pc_i            ( pc            ),
    .instr_valid_i   ( instr_valid   ),
    .stall_i         ( stall         ),
    .branch_taken_o  ( branch_taken  ),
    .branch_target_o ( branch_target ),
    .trap_o          ( trap          ),
    .wb_valid_o      ( wb_valid      ),
    .wb_rd_o         ( wb_rd         ),
    .wb_data_o       ( wb_data       )
);

always #10 clk = ~clk;

//////////////////////////////////////////////////
// Random numbers and encoders

function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed ^ (seed >> 16);  // Mix high bits down
endfunction

function automatic int unsigned pick(input int unsigned n);
    return next_rand() % n;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Random OP or OP-IMM reading rs1, legal funct7 only
function automatic logic [31:0] random_alu(input logic [4:0] rs1);
    logic [2:0]  f3;
    logic [4:0]  rd, rs2;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'(pick(8));
    rd  = 5'(pick(16));
    rs2 = 5'(pick(16));
    alt = pick(2) == 1;
    imm = 12'(next_rand());
    if (pick(2) == 1) begin
        return enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
    end
    if (f3 == 3'd1) begin
        imm = {7'h00, rs2};
    end else if (f3 == 3'd5) begin
        imm = {alt ? 7'h20 : 7'h00, rs2};  // SRAI or SRLI
    end
    return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
endfunction

//////////////////////////////////////////////////
// RV32I reference

function automatic logic [31:0] rv_arith(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return (a >> b[4:0]) | ({32{alt & a[31]}} & ~(32'hffff_ffff >> b[4:0]));
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic void predict(input logic [31:0] w);
    logic [31:0] a, b, imm_i;
    a        = shadow[w[19:15]];
    b        = shadow[w[24:20]];
    imm_i    = {{20{w[31]}}, w[31:20]};
    p_rd     = w[11:7];
    p_wr     = w[11:7] != 5'd0;
    p_taken  = 1'b0;
    p_target = '0;
    p_data   = '0;
    case (w[6:0])
        OPC_OP:     p_data = rv_arith(w[14:12], w[30], a, b);
        OPC_OP_IMM: p_data = rv_arith(w[14:12], w[14:12] == 3'd5 && w[30], a, imm_i);
        OPC_LUI:    p_data = {w[31:12], 12'b0};
        OPC_AUIPC:  p_data = cur_pc + {w[31:12], 12'b0};
        OPC_JAL: begin
            p_data   = cur_pc + 32'd4;
            p_taken  = 1'b1;
            p_target = cur_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        OPC_JALR: begin
            p_data   = cur_pc + 32'd4;
            p_taken  = 1'b1;
            p_target = (a + imm_i) & ~32'd1;
        end
        default: begin  // Conditional branch
            p_wr     = 1'b0;
            p_taken  = branch_cond(w[14:12], a, b);
            p_target = cur_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
    endcase
    p_trap = p_taken && p_target[1];
endfunction

//////////////////////////////////////////////////
// Stimulus

// One cycle at the input, then update the expected pipeline
task automatic offer(input logic [31:0] w, input logic valid, input logic hold);
    instr       = w;
    pc          = cur_pc;
    instr_valid = valid;
    stall       = hold;
    predict(w);
    @(posedge clk);
    accepted     = valid && !hold && !ex_taken;  // Taken branch cancels the offer
    exp_wb_valid = !hold && ex_wr;
    if (!hold) begin
        ex_valid  = accepted;
        ex_wr     = accepted && p_wr;
        ex_taken  = accepted && p_taken;
        ex_trap   = accepted && p_trap;
        ex_target = p_taken ? p_target : cur_pc + 32'd4;  // Next pc either way
    end
    if (accepted) begin
        if (p_wr) begin
            shadow[p_rd] = p_data;
            exp_rd_q.push_back(p_rd);
            exp_data_q.push_back(p_data);
        end
        cur_pc = p_taken ? p_target : cur_pc + 32'd4;
    end
    #2;
endtask

task automatic issue(input logic [31:0] w, input int stall_pct);
    accepted = 1'b0;
    while (!accepted) begin
        offer(w, 1'b1, pick(100) < stall_pct);
    end
endtask

task automatic idle(input int n);
    repeat (n) offer(32'h0, 1'b0, 1'b0);
endtask

task automatic write_reg(input logic [4:0] r, input logic [31:0] v);
    logic [19:0] hi;
    hi = v[31:12] + 20'(v[11]);  // ADDI sign-extends the low part
    issue({hi, r, OPC_LUI}, 0);
    issue(enc_i(v[11:0], r, 3'd0, r, OPC_OP_IMM), 0);
endtask

task automatic end_test(input string name);
    idle(DRAIN);
    tests_run++;
    if (errors == errors_at_start) begin
        $display("Test %0d %s: ok", tests_run, name);
    end else begin
        $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        tests_failed++;
    end
    errors_at_start = errors;
endtask

task automatic value_error(input string name, input logic [31:0] exp_v,
                           input logic [31:0] got_v);
    $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, got_v);
    errors++;
endtask

//////////////////////////////////////////////////
// Checks, sampled mid-cycle

always @(negedge clk) begin
    checks++;
    assert (wb_valid == exp_wb_valid)
        else value_error("wb_valid_o", 32'(exp_wb_valid), 32'(wb_valid));
    assert (branch_taken == ex_taken)
        else value_error("branch_taken_o", 32'(ex_taken), 32'(branch_taken));
    assert (trap == ex_trap)
        else value_error("trap_o", 32'(ex_trap), 32'(trap));
    if (ex_valid) begin
        assert (branch_target == ex_target)
            else value_error("branch_target_o", ex_target, branch_target);
    end
    if (wb_valid) begin
        assert (exp_rd_q.size() > 0) else begin
            $display("Error at %0t ns: writeback to x%0d with nothing outstanding",
                     $time, wb_rd);
            errors++;
        end
        if (exp_rd_q.size() > 0) begin
            assert (wb_rd == exp_rd_q[0])
                else value_error("wb_rd_o", 32'(exp_rd_q[0]), 32'(wb_rd));
            assert (wb_data == exp_data_q[0])
                else value_error("wb_data_o", exp_data_q[0], wb_data);
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
        end
    end
end

always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end
end

initial begin
    logic [4:0] prev;
    logic [2:0] f3;
    logic [4:0] rs;
    rst_n        = 1'b0;
    instr        = '0;
    pc           = '0;
    instr_valid  = 1'b0;
    stall        = 1'b0;
    cur_pc       = 32'h0000_1000;
    ex_valid     = 1'b0;
    ex_wr        = 1'b0;
    ex_taken     = 1'b0;
    ex_trap      = 1'b0;
    ex_target    = '0;
    exp_wb_valid = 1'b0;
    for (int r = 0; r < 32; r++) begin
        shadow[r] = '0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    idle(20);
    end_test("reset and idle");

    for (int r = 1; r < 16; r++) begin
        base_vals[r] = next_rand();
        write_reg(5'(r), base_vals[r]);
    end
    for (int i = 0; i < N_RANDOM; i++) begin
        issue(random_alu(5'(pick(16))), 0);
    end
    end_test("random ALU");

    // Same dependent chain with gaps, then back to back
    prev = 5'd1;
    for (int i = 0; i < N_CHAIN; i++) begin
        chain[i] = random_alu(prev);
        prev     = chain[i][11:7];
    end
    for (int r = 1; r < 16; r++) begin
        write_reg(5'(r), base_vals[r]);
    end
    for (int i = 0; i < N_CHAIN; i++) begin
        issue(chain[i], 0);
        idle(1);
    end
    for (int r = 1; r < 16; r++) begin
        write_reg(5'(r), base_vals[r]);
    end
    for (int i = 0; i < N_CHAIN; i++) begin
        issue(chain[i], 0);
    end
    end_test("bypass chain");

    for (int i = 0; i < N_BRANCH; i++) begin
        f3 = 3'(pick(6));
        if (f3 >= 3'd2) begin
            f3 = f3 + 3'd2;  // Skip the two reserved encodings
        end
        rs = 5'(pick(8));
        issue(enc_b(13'(pick(64)) * 13'd2 - 13'd64, 5'(pick(8)), rs, f3), 0);
        offer(enc_i(12'(next_rand()), 5'(pick(16)), 3'd0, 5'(pick(16)), OPC_OP_IMM),
              1'b1, 1'b0);
    end
    end_test("branches");

    for (int i = 0; i < N_JUMP; i++) begin
        issue({20'(next_rand()), 5'(pick(16)), OPC_AUIPC}, 0);  // pc-relative link base
        if (pick(2) == 1) begin
            issue(enc_j(21'(pick(256)) * 21'd2 - 21'd256, 5'(pick(16))), 0);
        end else begin
            issue(enc_i(12'(next_rand()), 5'(pick(16)), 3'd0, 5'(pick(16)), OPC_JALR), 0);
        end
        offer(enc_i(12'(next_rand()), 5'(pick(16)), 3'd0, 5'(pick(16)), OPC_OP_IMM),
              1'b1, 1'b0);
    end
    end_test("jumps and traps");

    prev = 5'd1;
    for (int i = 0; i < N_STALLED; i++) begin
        chain[0] = random_alu(prev);
        issue(chain[0], 30);
        prev = chain[0][11:7];
    end
    end_test("stalled chain");

    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

//--- filelist.f
hw/core_pkg.sv
hw/alu.sv
hw/id_decode.sv
hw/ex_stage.sv
hw/wb_result.sv
hw/exec_core_top.sv
bench/tb_exec_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
